// ==== src/sys1_pkg.sv ====
// #########################################################################
// Shared types, region map, bank widths, key codes and slapstic constants
// #########################################################################

package sys1_pkg;

	// Payload and address types
	typedef logic [24:0] dl_addr_t;
	typedef logic [15:0] word_t;
	typedef logic [7:0]  byte_t;

	// Write targets, main word banks first
	typedef enum logic [3:0] {
		BANK_SYS0, BANK_ROM1, BANK_ROM2, BANK_ROM3, BANK_SLAP,
		BANK_SND0, BANK_SND1, BANK_SND2, BANK_PROM4A, BANK_PROM7A
	} bank_e;

	localparam int N_BANKS = 10;

	// Banks written as 16-bit words, one bit per bank_e value
	localparam logic [N_BANKS-1:0] WORD_BANK_MASK = 10'b00000_11111;

	// ##########################################################################
	// Download region map, byte base and byte span
	// ##########################################################################
	localparam dl_addr_t ROM1_BASE   = 25'h80000;
	localparam dl_addr_t ROM1_SPAN   = 25'h10000;
	localparam dl_addr_t ROM2_BASE   = 25'h90000;
	localparam dl_addr_t ROM2_SPAN   = 25'h10000;
	localparam dl_addr_t ROM3_BASE   = 25'hA0000;
	localparam dl_addr_t ROM3_SPAN   = 25'h08000;
	localparam dl_addr_t SLAP_BASE   = 25'hA8000;
	localparam dl_addr_t SLAP_SPAN   = 25'h08000;
	localparam dl_addr_t SYS0_BASE   = 25'hB0000;
	localparam dl_addr_t SYS0_SPAN   = 25'h08000;
	localparam dl_addr_t SND0_BASE   = 25'hB8000;
	localparam dl_addr_t SND0_SPAN   = 25'h04000;
	localparam dl_addr_t SND1_BASE   = 25'hBC000;
	localparam dl_addr_t SND1_SPAN   = 25'h04000;
	localparam dl_addr_t SND2_BASE   = 25'hC0000;
	localparam dl_addr_t SND2_SPAN   = 25'h04000;
	localparam dl_addr_t PROM4A_BASE = 25'hC6000;
	localparam dl_addr_t PROM4A_SPAN = 25'h00200;
	localparam dl_addr_t PROM7A_BASE = 25'hC6200;
	localparam dl_addr_t PROM7A_SPAN = 25'h00200;

	// Bank address widths
	localparam int MAIN_AW_WIDE   = 15;
	localparam int MAIN_AW_NARROW = 14;
	localparam int SND_AW         = 14;
	localparam int PROM_AW        = 9;
	localparam int MADDR_W        = 15;

	// Download index values and slapstic type
	localparam byte_t IDX_ROM   = 8'd0;
	localparam byte_t IDX_SLAP  = 8'd1;
	localparam byte_t SLAP_INDY = 8'd105;

	// ##########################################################################
	// Keyboard codes, extended flag in bit 8
	// ##########################################################################
	localparam logic [8:0] KEY_P1_UP    = 9'h175;
	localparam logic [8:0] KEY_P1_DOWN  = 9'h172;
	localparam logic [8:0] KEY_P1_LEFT  = 9'h16B;
	localparam logic [8:0] KEY_P1_RIGHT = 9'h174;
	localparam logic [8:0] KEY_P1_START = 9'h014;
	localparam logic [8:0] KEY_P1_JUMP  = 9'h011;
	localparam logic [8:0] KEY_P2_UP    = 9'h02D;
	localparam logic [8:0] KEY_P2_DOWN  = 9'h02B;
	localparam logic [8:0] KEY_P2_LEFT  = 9'h023;
	localparam logic [8:0] KEY_P2_RIGHT = 9'h034;
	localparam logic [8:0] KEY_P2_START = 9'h01C;
	localparam logic [8:0] KEY_P2_JUMP  = 9'h01B;
	localparam logic [8:0] KEY_COIN_L   = 9'h02E;
	localparam logic [8:0] KEY_COIN_R   = 9'h036;
	localparam logic [8:0] KEY_COIN_AUX = 9'h03D;

	// Player byte: up, down, left, right in 7..4, start in 1, jump in 0
	typedef struct packed {
		logic [7:0] p1;
		logic [7:0] p2;
		logic       coin_l;
		logic       coin_r;
		logic       coin_aux;
	} ctl_bits_t;

endpackage

// ==== src/rom_wr_if.sv ====
// #########################################################################
// Bank write bus from download decoder to ROM array
// #########################################################################

`timescale 1ns/100ps

interface rom_wr_if;
	import sys1_pkg::*;

	// One-cycle write pulse per bank
	logic [N_BANKS-1:0] we;
	// Full download byte address, banks take their own slice
	dl_addr_t           addr;
	// Assembled word for main banks
	word_t              word;
	// Raw byte for sound banks and PROMs
	byte_t              byte_data;

	modport source (output we, output addr, output word, output byte_data);
	modport sink   (input we, input addr, input word, input byte_data);

endinterface

// ==== src/rom_bank.sv ====
// #########################################################################
// Simple dual-port ROM bank, download write port and registered read
// #########################################################################

`timescale 1ns/100ps

module rom_bank #(
	parameter int  aw     = 14,
	parameter type data_t = logic [7:0]
) (
	input  logic          clk_sys,
	input  logic          we,
	input  logic [aw-1:0] waddr,
	input  data_t         wdata,
	input  logic [aw-1:0] raddr,
	output data_t         rdata
);

	// Contents come only from the download
	data_t mem [2**aw];

	// Download side
	always_ff @(posedge clk_sys) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// CPU side, one cycle latency
	always_ff @(posedge clk_sys) begin
		rdata <= mem[raddr];
	end

endmodule

// ==== src/download_decoder.sv ====
// #########################################################################
// Download decoder: byte qualification, word assembly, region decode,
// registered bank write pulses and slapstic type register
// #########################################################################

`timescale 1ns/100ps

module download_decoder (
	input  logic              clk_sys,
	input  logic              arst_n,
	input  logic              dl_wr,
	input  logic              dl_download,
	input  sys1_pkg::byte_t   dl_index,
	input  sys1_pkg::dl_addr_t dl_addr,
	input  sys1_pkg::byte_t   dl_data,
	rom_wr_if.source          wr,
	output sys1_pkg::byte_t   slap_type
);
	import sys1_pkg::*;

	logic               dl_ok;
	logic [N_BANKS-1:0] hit;
	logic [N_BANKS-1:0] we_d;
	byte_t              acc_q;

	// Address inside [base, base + span)
	function automatic logic in_region(dl_addr_t a, dl_addr_t base, dl_addr_t span);
		return (a >= base) && (a < base + span);
	endfunction

	// Only ROM downloads reach the banks
	assign dl_ok = dl_wr && dl_download && (dl_index == IDX_ROM);

	// ##########################################################################
	// Region decode
	// ##########################################################################
	always_comb begin
		hit              = '0;
		hit[BANK_SYS0]   = in_region(dl_addr, SYS0_BASE, SYS0_SPAN);
		hit[BANK_ROM1]   = in_region(dl_addr, ROM1_BASE, ROM1_SPAN);
		hit[BANK_ROM2]   = in_region(dl_addr, ROM2_BASE, ROM2_SPAN);
		hit[BANK_ROM3]   = in_region(dl_addr, ROM3_BASE, ROM3_SPAN);
		hit[BANK_SLAP]   = in_region(dl_addr, SLAP_BASE, SLAP_SPAN);
		hit[BANK_SND0]   = in_region(dl_addr, SND0_BASE, SND0_SPAN);
		hit[BANK_SND1]   = in_region(dl_addr, SND1_BASE, SND1_SPAN);
		hit[BANK_SND2]   = in_region(dl_addr, SND2_BASE, SND2_SPAN);
		hit[BANK_PROM4A] = in_region(dl_addr, PROM4A_BASE, PROM4A_SPAN);
		hit[BANK_PROM7A] = in_region(dl_addr, PROM7A_BASE, PROM7A_SPAN);
	end

	// Word banks write on the odd byte only, byte banks on every byte
	assign we_d = dl_ok ? (hit & (dl_addr[0] ? '1 : ~WORD_BANK_MASK)) : '0;

	// Previous byte becomes the high half of the next word
	always_ff @(posedge clk_sys) begin
		if (dl_ok) begin
			acc_q <= dl_data;
		end
	end

	// Write pulses, one cycle after the qualifying strobe
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			wr.we <= '0;
		end else begin
			wr.we <= we_d;
		end
	end

	// Address and data registered alongside the pulse
	always_ff @(posedge clk_sys) begin
		wr.addr      <= dl_addr;
		wr.word      <= {acc_q, dl_data};
		wr.byte_data <= dl_data;
	end

	// Slapstic type, loaded by index 1 regardless of download level
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			slap_type <= SLAP_INDY;
		end else if (dl_wr && (dl_index == IDX_SLAP)) begin
			slap_type <= dl_data;
		end
	end

endmodule

// ==== src/rom_array.sv ====
// #########################################################################
// Main, sound and PROM banks with registered select priority muxes
// #########################################################################

`timescale 1ns/100ps

module rom_array (
	input  logic                           clk_sys,
	input  logic                           arst_n,
	rom_wr_if.sink                         wr,
	input  logic [3:0]                     rom_sel_n,
	input  logic                           slap_n,
	input  logic [sys1_pkg::MADDR_W-1:0]   maddr,
	input  logic [2:0]                     srom_sel_n,
	input  logic [sys1_pkg::SND_AW-1:0]    sba,
	input  logic [sys1_pkg::PROM_AW-1:0]   paddr,
	output sys1_pkg::word_t                mdata,
	output sys1_pkg::byte_t                sdata,
	output sys1_pkg::byte_t                pd4a,
	output sys1_pkg::byte_t                pd7a
);
	import sys1_pkg::*;

	word_t      sys0_q, rom1_q, rom2_q, rom3_q, slap_q;
	byte_t      snd0_q, snd1_q, snd2_q;
	logic [3:0] rom_sel_n_q;
	logic       slap_n_q;
	logic [2:0] srom_sel_n_q;

	// ##########################################################################
	// Main word banks, word address is byte address without bit 0
	// ##########################################################################
	rom_bank #(.aw(MAIN_AW_NARROW), .data_t(word_t)) sys0_i (
		.clk_sys(clk_sys), .we(wr.we[BANK_SYS0]), .waddr(wr.addr[MAIN_AW_NARROW:1]),
		.wdata(wr.word), .raddr(maddr[MAIN_AW_NARROW-1:0]), .rdata(sys0_q)
	);
	rom_bank #(.aw(MAIN_AW_WIDE), .data_t(word_t)) rom1_i (
		.clk_sys(clk_sys), .we(wr.we[BANK_ROM1]), .waddr(wr.addr[MAIN_AW_WIDE:1]),
		.wdata(wr.word), .raddr(maddr), .rdata(rom1_q)
	);
	rom_bank #(.aw(MAIN_AW_WIDE), .data_t(word_t)) rom2_i (
		.clk_sys(clk_sys), .we(wr.we[BANK_ROM2]), .waddr(wr.addr[MAIN_AW_WIDE:1]),
		.wdata(wr.word), .raddr(maddr), .rdata(rom2_q)
	);
	rom_bank #(.aw(MAIN_AW_NARROW), .data_t(word_t)) rom3_i (
		.clk_sys(clk_sys), .we(wr.we[BANK_ROM3]), .waddr(wr.addr[MAIN_AW_NARROW:1]),
		.wdata(wr.word), .raddr(maddr[MAIN_AW_NARROW-1:0]), .rdata(rom3_q)
	);
	// Slapstic banked ROM
	rom_bank #(.aw(MAIN_AW_NARROW), .data_t(word_t)) slap_i (
		.clk_sys(clk_sys), .we(wr.we[BANK_SLAP]), .waddr(wr.addr[MAIN_AW_NARROW:1]),
		.wdata(wr.word), .raddr(maddr[MAIN_AW_NARROW-1:0]), .rdata(slap_q)
	);

	// ##########################################################################
	// Sound byte banks and PROMs
	// ##########################################################################
	rom_bank #(.aw(SND_AW), .data_t(byte_t)) snd0_i (
		.clk_sys(clk_sys), .we(wr.we[BANK_SND0]), .waddr(wr.addr[SND_AW-1:0]),
		.wdata(wr.byte_data), .raddr(sba), .rdata(snd0_q)
	);
	rom_bank #(.aw(SND_AW), .data_t(byte_t)) snd1_i (
		.clk_sys(clk_sys), .we(wr.we[BANK_SND1]), .waddr(wr.addr[SND_AW-1:0]),
		.wdata(wr.byte_data), .raddr(sba), .rdata(snd1_q)
	);
	rom_bank #(.aw(SND_AW), .data_t(byte_t)) snd2_i (
		.clk_sys(clk_sys), .we(wr.we[BANK_SND2]), .waddr(wr.addr[SND_AW-1:0]),
		.wdata(wr.byte_data), .raddr(sba), .rdata(snd2_q)
	);
	// Both PROMs share one address
	rom_bank #(.aw(PROM_AW), .data_t(byte_t)) prom4a_i (
		.clk_sys(clk_sys), .we(wr.we[BANK_PROM4A]), .waddr(wr.addr[PROM_AW-1:0]),
		.wdata(wr.byte_data), .raddr(paddr), .rdata(pd4a)
	);
	rom_bank #(.aw(PROM_AW), .data_t(byte_t)) prom7a_i (
		.clk_sys(clk_sys), .we(wr.we[BANK_PROM7A]), .waddr(wr.addr[PROM_AW-1:0]),
		.wdata(wr.byte_data), .raddr(paddr), .rdata(pd7a)
	);

	// Selects delayed to line up with the bank read data
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rom_sel_n_q  <= '1;
			slap_n_q     <= 1'b1;
			srom_sel_n_q <= '1;
		end else begin
			rom_sel_n_q  <= rom_sel_n;
			slap_n_q     <= slap_n;
			srom_sel_n_q <= srom_sel_n;
		end
	end

	// Main priority: sys0, rom1, rom2, rom3, slapstic
	always_comb begin
		if (!rom_sel_n_q[0])      mdata = sys0_q;
		else if (!rom_sel_n_q[1]) mdata = rom1_q;
		else if (!rom_sel_n_q[2]) mdata = rom2_q;
		else if (!rom_sel_n_q[3]) mdata = rom3_q;
		else if (!slap_n_q)       mdata = slap_q;
		else                      mdata = '0;
	end

	// Sound priority
	always_comb begin
		if (!srom_sel_n_q[0])      sdata = snd0_q;
		else if (!srom_sel_n_q[1]) sdata = snd1_q;
		else if (!srom_sel_n_q[2]) sdata = snd2_q;
		else                       sdata = '0;
	end

endmodule

// ==== src/control_mapper.sv ====
// #########################################################################
// Keyboard decoder, joystick merge and active-low control formatting
// #########################################################################

`timescale 1ns/100ps

module control_mapper (
	input  logic            clk_sys,
	input  logic            arst_n,
	input  logic [10:0]     ps2_key,
	input  logic [15:0]     joy0,
	input  logic [15:0]     joy1,
	input  logic            service,
	input  sys1_pkg::byte_t slap_type,
	output logic [7:0]      joy_bits,
	output logic [4:0]      pb_n,
	output logic [2:0]      coin_n,
	output logic            selftest_n
);
	import sys1_pkg::*;

	ctl_bits_t  ctl_q;
	logic       tog_q;
	logic       pressed;
	logic [3:0] dir;

	assign pressed = ps2_key[9];

	// ##########################################################################
	// Key events, a change of bit 10 marks a new make or break
	// ##########################################################################
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			tog_q <= 1'b0;
			ctl_q <= '0;
		end else begin
			tog_q <= ps2_key[10];
			if (tog_q != ps2_key[10]) begin
				case (ps2_key[8:0])
					// Player 1, arrows and left ctrl/alt
					KEY_P1_UP:    ctl_q.p1[7]    <= pressed;
					KEY_P1_DOWN:  ctl_q.p1[6]    <= pressed;
					KEY_P1_LEFT:  ctl_q.p1[5]    <= pressed;
					KEY_P1_RIGHT: ctl_q.p1[4]    <= pressed;
					KEY_P1_START: ctl_q.p1[1]    <= pressed;
					KEY_P1_JUMP:  ctl_q.p1[0]    <= pressed;
					// Player 2, R F D G A S
					KEY_P2_UP:    ctl_q.p2[7]    <= pressed;
					KEY_P2_DOWN:  ctl_q.p2[6]    <= pressed;
					KEY_P2_LEFT:  ctl_q.p2[5]    <= pressed;
					KEY_P2_RIGHT: ctl_q.p2[4]    <= pressed;
					KEY_P2_START: ctl_q.p2[1]    <= pressed;
					KEY_P2_JUMP:  ctl_q.p2[0]    <= pressed;
					// Coins on 5, 6, 7
					KEY_COIN_L:   ctl_q.coin_l   <= pressed;
					KEY_COIN_R:   ctl_q.coin_r   <= pressed;
					KEY_COIN_AUX: ctl_q.coin_aux <= pressed;
					// Anything else is not a control
					default: ;
				endcase
			end
		end
	end

	// Merged up, down, left, right from keyboard and both sticks
	assign dir = ctl_q.p2[7:4] | ctl_q.p1[7:4] | joy1[3:0] | joy0[3:0];

	// Indy reads the ADC one position higher
	assign joy_bits = (slap_type == SLAP_INDY) ? {3'b000, dir, 1'b0} : {4'b0000, dir};

	// SW5 and SW4 unused, then jump, P2 start, P1 start
	assign pb_n = {
		2'b11,
		~(ctl_q.p1[0] | ctl_q.p2[0] | joy0[5] | joy1[5]),
		~(ctl_q.p2[1] | joy0[5] | joy1[5]),
		~(ctl_q.p1[1] | joy0[4] | joy1[4])
	};

	// Aux, right, left coin
	assign coin_n = {~ctl_q.coin_aux, ~ctl_q.coin_r, ~(ctl_q.coin_l | joy0[8])};

	assign selftest_n = ~service;

endmodule

// ==== src/sys1_board_io.sv ====
// #########################################################################
// Board I/O top: download decoder, ROM array and control mapper
// #########################################################################

`timescale 1ns/100ps

module sys1_board_io (
	// Clock and reset
	input  logic        clk_sys,
	input  logic        arst_n,
	// ROM download stream
	input  logic        dl_wr,
	input  logic        dl_download,
	input  logic [7:0]  dl_index,
	input  logic [24:0] dl_addr,
	input  logic [7:0]  dl_data,
	// Main CPU ROM read
	input  logic [3:0]  rom_sel_n,
	input  logic        slap_n,
	input  logic [14:0] maddr,
	output logic [15:0] mdata,
	// Sound CPU ROM read
	input  logic [2:0]  srom_sel_n,
	input  logic [13:0] sba,
	output logic [7:0]  sdata,
	// PROM read
	input  logic [8:0]  paddr,
	output logic [7:0]  pd4a,
	output logic [7:0]  pd7a,
	// Player controls
	input  logic [10:0] ps2_key,
	input  logic [15:0] joy0,
	input  logic [15:0] joy1,
	input  logic        service,
	output logic [7:0]  joy_bits,
	output logic [4:0]  pb_n,
	output logic [2:0]  coin_n,
	output logic        selftest_n
);
	import sys1_pkg::*;

	byte_t slap_type;

	// Download to bank write bus
	rom_wr_if wr_bus ();

	download_decoder download_decoder_i (
		.clk_sys(clk_sys), .arst_n(arst_n),
		.dl_wr(dl_wr), .dl_download(dl_download), .dl_index(dl_index),
		.dl_addr(dl_addr), .dl_data(dl_data),
		.wr(wr_bus.source), .slap_type(slap_type)
	);

	rom_array rom_array_i (
		.clk_sys(clk_sys), .arst_n(arst_n), .wr(wr_bus.sink),
		.rom_sel_n(rom_sel_n), .slap_n(slap_n), .maddr(maddr),
		.srom_sel_n(srom_sel_n), .sba(sba), .paddr(paddr),
		.mdata(mdata), .sdata(sdata), .pd4a(pd4a), .pd7a(pd7a)
	);

	// Slapstic type also picks the joystick layout
	control_mapper control_mapper_i (
		.clk_sys(clk_sys), .arst_n(arst_n), .ps2_key(ps2_key),
		.joy0(joy0), .joy1(joy1), .service(service), .slap_type(slap_type),
		.joy_bits(joy_bits), .pb_n(pb_n), .coin_n(coin_n), .selftest_n(selftest_n)
	);

endmodule

// ==== tb/tb_sys1_board_io.sv ====
// ###########################################################################
// Testbench for the board I/O top driven by a command file of
// downloads, ROM reads, key events and control checks
// ###########################################################################

`timescale 1ns/100ps

module tb_sys1_board_io;

	localparam int    RESET_CYCLES    = 5;
	localparam int    CYCLES_PER_LINE = 20;
	localparam string INPUT_FILE      = "tb/sys1_input.txt";

	// DUT inputs
	logic        clk_sys;
	logic        arst_n;
	logic        dl_wr;
	logic        dl_download;
	logic [7:0]  dl_index;
	logic [24:0] dl_addr;
	logic [7:0]  dl_data;
	logic [3:0]  rom_sel_n;
	logic        slap_n;
	logic [14:0] maddr;
	logic [2:0]  srom_sel_n;
	logic [13:0] sba;
	logic [8:0]  paddr;
	logic [10:0] ps2_key;
	logic [15:0] joy0;
	logic [15:0] joy1;
	logic        service;
	// DUT outputs
	logic [15:0] mdata;
	logic [7:0]  sdata;
	logic [7:0]  pd4a;
	logic [7:0]  pd7a;
	logic [7:0]  joy_bits;
	logic [4:0]  pb_n;
	logic [2:0]  coin_n;
	logic        selftest_n;

	// Bookkeeping
	int errors      = 0;
	int test_errs   = 0;
	int tests_ok    = 0;
	int tests_bad   = 0;
	int cycles      = 0;
	int cycle_limit = 0;

	sys1_board_io sys1_board_io_i (
		.clk_sys(clk_sys), .arst_n(arst_n),
		.dl_wr(dl_wr), .dl_download(dl_download), .dl_index(dl_index),
		.dl_addr(dl_addr), .dl_data(dl_data),
		.rom_sel_n(rom_sel_n), .slap_n(slap_n), .maddr(maddr), .mdata(mdata),
		.srom_sel_n(srom_sel_n), .sba(sba), .sdata(sdata),
		.paddr(paddr), .pd4a(pd4a), .pd7a(pd7a),
		.ps2_key(ps2_key), .joy0(joy0), .joy1(joy1), .service(service),
		.joy_bits(joy_bits), .pb_n(pb_n), .coin_n(coin_n), .selftest_n(selftest_n)
	);

	// 4 ns clock
	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// ########################################################################
	// Driving helpers that change inputs 1 ns after the rising edge
	// ########################################################################
	task automatic step_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic note_error();
		errors++;
		test_errs++;
	endtask

	// Ends a download group with strobe and level dropping together
	task automatic close_download();
		if (dl_wr || dl_download) begin
			step_cycle();
			dl_wr       = 1'b0;
			dl_download = 1'b0;
		end
	endtask

	// Back-to-back bytes while the download level stays high
	task automatic download_byte(input logic [7:0] idx, input logic [24:0] addr,
			input logic [7:0] data);
		if (!dl_download) begin
			step_cycle();
			dl_download = 1'b1;
		end
		step_cycle();
		dl_wr    = 1'b1;
		dl_index = idx;
		dl_addr  = addr;
		dl_data  = data;
	endtask

	// Byte with the download level low and room for a wrong write to land
	task automatic stray_byte(input logic [7:0] idx, input logic [24:0] addr,
			input logic [7:0] data);
		close_download();
		step_cycle();
		dl_wr    = 1'b1;
		dl_index = idx;
		dl_addr  = addr;
		dl_data  = data;
		step_cycle();
		dl_wr = 1'b0;
		step_cycle();
	endtask

	// ########################################################################
	// Checking helpers for the one cycle read latency
	// ########################################################################
	task automatic read_main(input logic [4:0] sel, input logic [14:0] addr,
			input logic [15:0] exp);
		close_download();
		step_cycle();
		{slap_n, rom_sel_n} = sel;
		maddr               = addr;
		step_cycle();
		assert (mdata == exp) else begin
			$display("Fail at %0d ns: mdata %h, expected %h (selects %b, address %h)",
				$time, mdata, exp, sel, addr);
			note_error();
		end
		{slap_n, rom_sel_n} = 5'h1F;
	endtask

	task automatic read_sound(input logic [2:0] sel, input logic [13:0] addr,
			input logic [7:0] exp);
		close_download();
		step_cycle();
		srom_sel_n = sel;
		sba        = addr;
		step_cycle();
		assert (sdata == exp) else begin
			$display("Fail at %0d ns: sdata %h, expected %h (selects %b, address %h)",
				$time, sdata, exp, sel, addr);
			note_error();
		end
		srom_sel_n = 3'h7;
	endtask

	task automatic read_prom(input logic [8:0] addr, input logic [7:0] exp_4a,
			input logic [7:0] exp_7a);
		close_download();
		step_cycle();
		paddr = addr;
		step_cycle();
		assert ((pd4a == exp_4a) && (pd7a == exp_7a)) else begin
			$display("Fail at %0d ns: PROM %h gives 4A %h 7A %h, expected %h %h",
				$time, addr, pd4a, pd7a, exp_4a, exp_7a);
			note_error();
		end
	endtask

	// Controls settle two edges after a change so three are waited
	task automatic check_controls(input logic [7:0] exp_joy, input logic [4:0] exp_pb,
			input logic [2:0] exp_coin, input logic exp_st);
		close_download();
		repeat (3) step_cycle();
		assert ({joy_bits, pb_n, coin_n, selftest_n} == {exp_joy, exp_pb, exp_coin, exp_st})
		else begin
			$display("Fail at %0d ns: controls %h %h %h %b, expected %h %h %h %b",
				$time, joy_bits, pb_n, coin_n, selftest_n, exp_joy, exp_pb, exp_coin, exp_st);
			note_error();
		end
	endtask

	task automatic finish_test(input int num);
		close_download();
		if (test_errs == 0) begin
			$display("Test %0d ok", num);
			tests_ok++;
		end else begin
			$display("Test %0d had %0d errors", num, test_errs);
			tests_bad++;
		end
		test_errs = 0;
	endtask

	// One command line with the letter first and hex fields after it
	task automatic run_command(input string line, input int line_no);
		logic [7:0]  cmd;
		logic [31:0] f0;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		int          n;
		cmd = line.getc(0);
		f0  = '0;
		f1  = '0;
		f2  = '0;
		f3  = '0;
		n   = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", f0, f1, f2, f3);
		case (cmd)
			"D": download_byte(f0[7:0], f1[24:0], f2[7:0]);
			"X": stray_byte(f0[7:0], f1[24:0], f2[7:0]);
			"K": begin
				close_download();
				step_cycle();
				// Toggle marks a new make or break event
				ps2_key = {~ps2_key[10], f1[0], f0[8:0]};
			end
			"J": begin
				close_download();
				step_cycle();
				joy0    = f0[15:0];
				joy1    = f1[15:0];
				service = f2[0];
			end
			"M": read_main(f0[4:0], f1[14:0], f2[15:0]);
			"S": read_sound(f0[2:0], f1[13:0], f2[7:0]);
			"P": read_prom(f0[8:0], f1[7:0], f2[7:0]);
			"C": check_controls(f0[7:0], f1[4:0], f2[2:0], f3[0]);
			"T": finish_test(int'(f0));
			default: begin
				$display("Unknown command in input line %0d with %0d fields", line_no, n);
				note_error();
			end
		endcase
	endtask

	// ########################################################################
	// Main sequence
	// ########################################################################
	initial begin
		string lines[$];
		string line;
		int    fd;
		int    n;
		dl_wr       = 1'b0;
		dl_download = 1'b0;
		dl_index    = '0;
		dl_addr     = '0;
		dl_data     = '0;
		rom_sel_n   = 4'hF;
		slap_n      = 1'b1;
		maddr       = '0;
		srom_sel_n  = 3'h7;
		sba         = '0;
		paddr       = '0;
		ps2_key     = '0;
		joy0        = '0;
		joy1        = '0;
		service     = 1'b0;
		arst_n      = 1'b0;

		// Whole command file read up front as its length sets the cycle limit
		fd = $fopen(INPUT_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the command file %s", INPUT_FILE);
			errors++;
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 0) lines.push_back(line);
			end
			$fclose(fd);
		end
		cycle_limit = CYCLES_PER_LINE * lines.size() + RESET_CYCLES;

		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1;
		arst_n = 1'b1;

		// Comment and empty lines are skipped
		foreach (lines[i]) begin
			if ((lines[i].len() > 1) && (lines[i].getc(0) != "#")) begin
				run_command(lines[i], i + 1);
			end
		end
		close_download();
		repeat (2) step_cycle();

		$display("Tests ok: %0d, tests with errors: %0d, failed checks: %0d",
			tests_ok, tests_bad, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		wait (cycle_limit > 0);
		while (cycles < cycle_limit) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout: the run did not end within %0d cycles", cycle_limit);
		$display("Testbench failed");
		$finish;
	end

endmodule

// ==== tb/sys1_input.txt ====
# Command letter then hex fields. D or X: index address data (X has dl_download low)
# K: code pressed. J: joy0 joy1 service. M or S: selects address expected
# P: address expected_4a expected_7a. C: joy_bits pb_n coin_n selftest_n. T: test
# M selects are {slap_n, rom_sel_n[3:0]}, S selects are srom_sel_n[2:0]
# Test 1: word assembly in rom1 and the slapstic region
D 00 80000 12
D 00 80001 34
D 00 80002 56
D 00 80003 78
M 1D 0000 1234
M 1D 0001 5678
D 00 A8010 9A
D 00 A8011 BC
M 0F 0008 9ABC
T 1
# Test 2: main select priority at word address 0x10
D 00 B0020 11
D 00 B0021 11
D 00 80020 22
D 00 80021 22
D 00 A0020 33
D 00 A0021 33
M 00 0010 1111
M 05 0010 2222
M 07 0010 3333
M 1F 0010 0000
T 2
# Test 3: sound banks, PROMs and unqualified bytes
D 00 B8005 A1
D 00 BC005 B2
D 00 C0005 C3
D 00 C6007 4D
D 00 C6207 7E
S 6 0005 A1
S 5 0005 B2
S 3 0005 C3
S 7 0005 00
P 007 4D 7E
X 00 B8005 FF
D 02 B8005 EE
S 6 0005 A1
X 00 C6207 FF
P 007 4D 7E
T 3
# Test 4: keyboard, coins, joystick buttons and service
C 00 1F 7 1
K 175 1
K 01C 1
C 10 1D 7 1
K 175 0
K 01C 0
C 00 1F 7 1
K 02E 1
C 00 1F 6 1
K 036 1
K 03D 1
C 00 1F 0 1
K 02E 0
K 036 0
K 03D 0
J 0100 0000 0
C 00 1F 6 1
J 0020 0000 1
C 00 19 7 0
J 0000 0000 0
C 00 1F 7 1
T 4
# Test 5: slapstic type moves the joystick layout
J 0001 0000 0
C 02 1F 7 1
D 01 00000 6B
C 01 1F 7 1
D 01 00000 69
C 02 1F 7 1
J 0000 0000 0
T 5

// ==== tb.f ====
src/sys1_pkg.sv
src/rom_wr_if.sv
src/rom_bank.sv
src/download_decoder.sv
src/rom_array.sv
src/control_mapper.sv
src/sys1_board_io.sv
tb/tb_sys1_board_io.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the board I/O testbench with Verilator, result taken from sim.log
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_sys1_board_io -Mdir obj_dir -f tb.f \
	&& ./obj_dir/Vtb_sys1_board_io > sim.log 2>&1 \
	|| { echo "Build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^Testbench passed$" sim.log \
	&& echo "Result: pass" \
	|| { echo "Result: fail"; exit 1; }
exit 0
